// File: src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// ########################################
// Data path widths
// ########################################

// Width of a data word and of a register.
`define MIPS_WORD_W 32

// Bytes per data word.
`define MIPS_WORD_BYTES (`MIPS_WORD_W / 8)

// ########################################
// Data RAM geometry
// ########################################

// Word address width of the data RAM, 256 words.
`define MIPS_DMEM_AW 8

`endif

// File: src/mips_pkg.sv
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0] word_t;

    // Decoded memory opcodes handed over by the execute stage.
    typedef enum logic [3:0] {
        NOP,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWL,
        LWR,
        SB,
        SH,
        SW,
        SWL,
        SWR
    } decoded_op_t;

    // ########################################
    // Stage payloads
    // ########################################

    typedef struct packed {
        logic        valid;
        decoded_op_t op;
        word_t       addr;     // Byte address.
        word_t       wdata;    // Store value, rt.
        word_t       reg_old;  // Old rt value, merged by LWL and LWR.
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        logic  addr_err;
        word_t rd;
    } mem_rsp_t;

    typedef struct packed {
        logic [`MIPS_WORD_BYTES-1:0] strb;
        word_t                       data;
    } store_lane_t;

endpackage

`default_nettype wire

// File: src/align_check.sv
`timescale 1ns/10ps
`default_nettype none

module align_check (
    input  mips_pkg::decoded_op_t op,
    input  logic [1:0]            addr_lo,
    output logic                  addr_err
);
    import mips_pkg::*;

    logic need_half;
    logic need_word;

    // Halfword ops need an even address, word ops a multiple of four.
    always_comb begin
        need_half = 1'b0;
        need_word = 1'b0;
        case (op)
            LH, LHU, SH: begin
                need_half = 1'b1;
            end
            LW, SW: begin
                need_word = 1'b1;
            end
            default: begin
                need_half = 1'b0;                // LWL, LWR, SWL and SWR take any offset.
                need_word = 1'b0;
            end
        endcase
    end

    assign addr_err = (need_half & addr_lo[0]) | (need_word & (|addr_lo));

endmodule

`default_nettype wire

// File: src/store_format.sv
`timescale 1ns/10ps
`default_nettype none

module store_format (
    input  mips_pkg::decoded_op_t op,
    input  logic [1:0]            addr_lo,
    input  mips_pkg::word_t       wdata,
    output mips_pkg::store_lane_t lane
);
    import mips_pkg::*;

    always_comb begin
        lane = '0;                               // Loads and NOP write nothing.
        case (op)
            SB: begin
                lane.data = {4{wdata[7:0]}};     // Byte sits in every lane.
                case (addr_lo)
                    2'b00: lane.strb = 4'b0001;
                    2'b01: lane.strb = 4'b0010;
                    2'b10: lane.strb = 4'b0100;
                    default: lane.strb = 4'b1000;
                endcase
            end
            SH: begin
                lane.data = {2{wdata[15:0]}};
                if (addr_lo[1]) begin
                    lane.strb = 4'b1100;
                end else begin
                    lane.strb = 4'b0011;
                end
            end
            SW: begin
                lane.strb = 4'b1111;
                lane.data = wdata;
            end
            SWL: begin
                // The top bytes of rt go to the low memory bytes.
                case (addr_lo)
                    2'b00: begin
                        lane.strb = 4'b0001;
                        lane.data = {24'b0, wdata[31:24]};
                    end
                    2'b01: begin
                        lane.strb = 4'b0011;
                        lane.data = {16'b0, wdata[31:16]};
                    end
                    2'b10: begin
                        lane.strb = 4'b0111;
                        lane.data = {8'b0, wdata[31:8]};
                    end
                    default: begin
                        lane.strb = 4'b1111;
                        lane.data = wdata;
                    end
                endcase
            end
            SWR: begin
                case (addr_lo)
                    2'b00: begin
                        lane.strb = 4'b1111;
                        lane.data = wdata;
                    end
                    2'b01: begin
                        lane.strb = 4'b1110;
                        lane.data = {wdata[23:0], 8'b0};
                    end
                    2'b10: begin
                        lane.strb = 4'b1100;
                        lane.data = {wdata[15:0], 16'b0};
                    end
                    default: begin
                        lane.strb = 4'b1000;
                        lane.data = {wdata[7:0], 24'b0};
                    end
                endcase
            end
            default: begin
                lane = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/dmem_access.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_defs.svh"

module dmem_access #(
    parameter int aw = `MIPS_DMEM_AW
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mips_pkg::mem_req_t    req,
    input  logic                  addr_err,
    input  mips_pkg::store_lane_t lane,
    output mips_pkg::word_t       rdata,
    output mips_pkg::mem_req_t    ctx,
    output logic                  ctx_err
);
    import mips_pkg::*;

    localparam int depth = 1 << aw;
    localparam int nbytes = `MIPS_WORD_BYTES;

    word_t         mem [depth];
    logic [aw-1:0] word_addr;
    logic          wr_en;

    mem_req_t      ctx_q;
    logic          err_q;

    assign word_addr = req.addr[aw+1:2];     // Byte offset is dropped.
    assign wr_en     = req.valid & ~addr_err;    // A faulting store leaves memory alone.

    // ########################################
    // Data RAM
    // ########################################

    always_ff @(posedge clk) begin
        for (int i = 0; i < nbytes; i++) begin
            if (wr_en && lane.strb[i]) begin
                mem[word_addr][8*i +: 8] <= lane.data[8*i +: 8];
            end
        end
    end

    // Synchronous read of the addressed word.
    always_ff @(posedge clk) begin
        rdata <= mem[word_addr];
    end

    // ########################################
    // Request context
    // ########################################

    always_ff @(posedge clk) begin
        ctx_q <= req;                            // Op, offset and reg_old for the formatter.
        if (!rst_n) begin
            ctx_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req.valid & addr_err;
        end
    end

    assign ctx     = ctx_q;
    assign ctx_err = err_q;

endmodule

`default_nettype wire

// File: src/readdata_format.sv
`timescale 1ns/10ps
`default_nettype none

module readdata_format (
    input  mips_pkg::word_t    rdata,
    input  mips_pkg::mem_req_t ctx,
    input  logic               ctx_err,
    output mips_pkg::mem_rsp_t rsp
);
    import mips_pkg::*;

    logic [1:0] ofs;
    word_t      old;
    word_t      rd;

    assign ofs = ctx.addr[1:0];
    assign old = ctx.reg_old;

    always_comb begin
        case (ctx.op)
            LB: begin
                case (ofs)
                    2'b00: rd = {{24{rdata[7]}}, rdata[7:0]};
                    2'b01: rd = {{24{rdata[15]}}, rdata[15:8]};
                    2'b10: rd = {{24{rdata[23]}}, rdata[23:16]};
                    default: rd = {{24{rdata[31]}}, rdata[31:24]};
                endcase
            end
            LBU: begin
                case (ofs)
                    2'b00: rd = {24'b0, rdata[7:0]};
                    2'b01: rd = {24'b0, rdata[15:8]};
                    2'b10: rd = {24'b0, rdata[23:16]};
                    default: rd = {24'b0, rdata[31:24]};
                endcase
            end
            LH: begin
                if (ofs[1]) begin
                    rd = {{16{rdata[31]}}, rdata[31:16]};
                end else begin
                    rd = {{16{rdata[15]}}, rdata[15:0]};
                end
            end
            LHU: begin
                if (ofs[1]) begin
                    rd = {16'b0, rdata[31:16]};
                end else begin
                    rd = {16'b0, rdata[15:0]};
                end
            end
            LWL: begin
                // Low memory bytes fill the top of the register.
                case (ofs)
                    2'b00: rd = {rdata[7:0], old[23:0]};
                    2'b01: rd = {rdata[15:0], old[15:0]};
                    2'b10: rd = {rdata[23:0], old[7:0]};
                    default: rd = rdata;
                endcase
            end
            LWR: begin
                case (ofs)
                    2'b00: rd = rdata;
                    2'b01: rd = {old[31:24], rdata[31:8]};
                    2'b10: rd = {old[31:16], rdata[31:16]};
                    default: rd = {old[31:8], rdata[31:24]};
                endcase
            end
            default: begin
                rd = rdata;                      // LW, stores and NOP see the raw word.
            end
        endcase
    end

    assign rsp.valid    = ctx.valid;
    assign rsp.addr_err = ctx_err;
    assign rsp.rd       = rd;

endmodule

`default_nettype wire

// File: src/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::mem_req_t req,
    output mips_pkg::mem_rsp_t rsp
);
    import mips_pkg::*;

    logic        addr_err;
    store_lane_t lane;
    word_t       rdata;
    mem_req_t    ctx;
    logic        ctx_err;

    align_check u_align_check (
        .op       (req.op),
        .addr_lo  (req.addr[1:0]),
        .addr_err (addr_err)
    );

    store_format u_store_format (
        .op      (req.op),
        .addr_lo (req.addr[1:0]),
        .wdata   (req.wdata),
        .lane    (lane)
    );

    dmem_access u_dmem_access (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .addr_err (addr_err),
        .lane     (lane),
        .rdata    (rdata),
        .ctx      (ctx),
        .ctx_err  (ctx_err)
    );

    readdata_format u_readdata_format (
        .rdata   (rdata),
        .ctx     (ctx),
        .ctx_err (ctx_err),
        .rsp     (rsp)
    );

endmodule

`default_nettype wire

// File: verification/mem_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mips_defs.svh"

module mem_stage_tb;
    import mips_pkg::*;

    localparam int aw = `MIPS_DMEM_AW;
    localparam int ab = `MIPS_DMEM_AW + 2;       // Byte address bits covered by the RAM.

    logic        clk;
    logic        rst_n;
    mem_req_t    req;
    mem_rsp_t    rsp;

    logic [7:0]  model_mem [1 << ab];
    logic        exp_valid;
    logic        exp_err;
    logic        exp_load;
    decoded_op_t exp_op;
    word_t       exp_addr;
    word_t       exp_rd;
    int          checks;
    int          errors;
    int          timeouts;
    int          req_sent;
    int          rsp_seen;

    mem_stage uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ########################################
    // Reference model
    // ########################################

    function automatic logic fault_expected(input decoded_op_t op, input logic [1:0] lo);
        case (op)
            LH, LHU, SH: return lo[0];
            LW, SW: return |lo;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic is_load_op(input decoded_op_t op);
        return (op == LB) || (op == LBU) || (op == LH) || (op == LHU) ||
               (op == LW) || (op == LWL) || (op == LWR);
    endfunction

    // Load result from the model bytes, following the load rule.
    function automatic word_t load_result(input decoded_op_t op, input word_t addr,
                                          input word_t old);
        logic [7:0] b [4];
        logic [1:0] k;
        word_t      res;
        int         kk;
        k  = addr[1:0];
        kk = int'(k);
        for (int n = 0; n < 4; n++) begin
            b[n] = model_mem[{addr[ab-1:2], n[1:0]}];
        end
        res = old;
        case (op)
            LB: res = {{24{b[k][7]}}, b[k]};
            LBU: res = {24'b0, b[k]};
            LH: res = {{16{b[{k[1], 1'b1}][7]}}, b[{k[1], 1'b1}], b[{k[1], 1'b0}]};
            LHU: res = {16'b0, b[{k[1], 1'b1}], b[{k[1], 1'b0}]};
            LW: res = {b[3], b[2], b[1], b[0]};
            LWL: begin
                for (int n = 0; n <= kk; n++) begin
                    res[8*(3-kk+n) +: 8] = b[n];     // Memory bytes 0 to k land on top.
                end
            end
            LWR: begin
                for (int n = 0; n <= 3 - kk; n++) begin
                    res[8*n +: 8] = b[2'(kk + n)];
                end
            end
            default: res = '0;
        endcase
        return res;
    endfunction

    function automatic void store_to_model(input decoded_op_t op, input word_t addr,
                                           input word_t wdata);
        logic [aw-1:0] wa;
        int            kk;
        int            j;
        wa = addr[ab-1:2];
        kk = int'(addr[1:0]);
        case (op)
            SB: model_mem[{wa, addr[1:0]}] = wdata[7:0];
            SH: begin
                model_mem[{wa, addr[1], 1'b0}] = wdata[7:0];
                model_mem[{wa, addr[1], 1'b1}] = wdata[15:8];
            end
            SW: begin
                for (int n = 0; n < 4; n++) begin
                    model_mem[{wa, n[1:0]}] = wdata[8*n +: 8];
                end
            end
            SWL: begin
                for (int n = 0; n <= kk; n++) begin
                    model_mem[{wa, n[1:0]}] = wdata[8*(3-kk+n) +: 8];
                end
            end
            SWR: begin
                for (int n = 0; n <= 3 - kk; n++) begin
                    j = kk + n;
                    model_mem[{wa, j[1:0]}] = wdata[8*n +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    // ########################################
    // Stimulus helpers
    // ########################################

    function automatic word_t make_addr(input logic [aw-1:0] widx, input logic [1:0] k);
        word_t a;
        a = $urandom();                              // Upper bits are ignored by the RAM.
        a[ab-1:0] = {widx, k};
        return a;
    endfunction

    function automatic word_t fill_word(input logic [aw-1:0] widx);
        return {widx ^ 8'ha5, ~widx, {widx[3:0], widx[7:4]}, widx + 8'h3c};
    endfunction

    task automatic send_req(input decoded_op_t op, input word_t addr, input word_t wdata,
                            input word_t old);
        mem_req_t r;
        r.valid   = 1'b1;
        r.op      = op;
        r.addr    = addr;
        r.wdata   = wdata;
        r.reg_old = old;
        @(posedge clk);
        req <= r;
        req_sent++;
    endtask

    task automatic send_idle();
        @(posedge clk);
        req <= '0;
    endtask

    // ########################################
    // Comparing process
    // ########################################

    task automatic check_response();
        checks++;
        if (rsp.valid === 1'b1) begin
            rsp_seen++;
        end
        assert (rsp.valid === exp_valid) else begin
            errors++;
            $display("** Error at %0t ns: rsp.valid is %b, expected %b",
                     $time, rsp.valid, exp_valid);
        end
        assert (rsp.addr_err === exp_err) else begin
            errors++;
            $display("** Error at %0t ns: %s at 0x%08h gave addr_err %b, expected %b",
                     $time, exp_op.name(), exp_addr, rsp.addr_err, exp_err);
        end
        if (exp_valid && exp_load && !exp_err) begin
            assert (rsp.rd === exp_rd) else begin
                errors++;
                $display("** Error at %0t ns: %s at 0x%08h gave rd 0x%08h, expected 0x%08h",
                         $time, exp_op.name(), exp_addr, rsp.rd, exp_rd);
            end
        end
    endtask

    // The request seen here is the one the next rising edge samples.
    task automatic record_request();
        if (rst_n === 1'b1 && req.valid === 1'b1) begin
            exp_valid = 1'b1;
            exp_op    = req.op;
            exp_addr  = req.addr;
            exp_err   = fault_expected(req.op, req.addr[1:0]);
            exp_load  = is_load_op(req.op);
            exp_rd    = load_result(req.op, req.addr, req.reg_old);
            if (!exp_err) begin
                store_to_model(req.op, req.addr, req.wdata);
            end
        end else begin
            exp_valid = 1'b0;
            exp_err   = 1'b0;
            exp_load  = 1'b0;
        end
    endtask

    initial begin : compare_responses
        logic armed;
        armed = 1'b0;
        forever begin
            @(negedge clk);
            if (armed) begin
                check_response();
            end
            record_request();
            armed = 1'b1;
        end
    end

    // ########################################
    // Test sequence
    // ########################################

    initial begin : run_tests
        word_t         r;
        word_t         d;
        logic [aw-1:0] idx;
        logic [3:0]    pick;
        int            wait_cycles;
        r = $urandom(8);
        req = '0;
        rst_n = 1'b0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        req_sent = 0;
        rsp_seen = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) send_idle();                      // Outputs must stay quiet.

        for (int i = 0; i < (1 << aw); i++) begin
            send_req(SW, make_addr(i[aw-1:0], 2'b00), fill_word(i[aw-1:0]), $urandom());
        end
        for (int i = 0; i < 32; i++) begin
            idx = aw'($urandom());
            d   = $urandom();
            send_req(SW, make_addr(idx, 2'b00), d, $urandom());
            send_req(LW, make_addr(idx, 2'b00), $urandom(), $urandom());
        end

        // Byte and halfword lanes.
        for (int i = 0; i < 8; i++) begin
            idx = aw'($urandom());
            for (int k = 0; k < 4; k++) begin
                send_req(SB, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(LB, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(LBU, make_addr(idx, k[1:0]), $urandom(), $urandom());
            end
            for (int h = 0; h < 2; h++) begin
                send_req(SH, make_addr(idx, {h[0], 1'b0}), $urandom(), $urandom());
                send_req(LH, make_addr(idx, {h[0], 1'b0}), $urandom(), $urandom());
                send_req(LHU, make_addr(idx, {h[0], 1'b0}), $urandom(), $urandom());
            end
        end

        // Unaligned word pieces.
        for (int i = 0; i < 8; i++) begin
            idx = aw'($urandom());
            for (int k = 0; k < 4; k++) begin
                send_req(SWL, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(LWL, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(LWR, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(SWR, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(LWL, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(LWR, make_addr(idx, k[1:0]), $urandom(), $urandom());
                send_req(LW, make_addr(idx, 2'b00), $urandom(), $urandom());
            end
        end

        // Misaligned accesses followed by an aligned read of the same word.
        for (int k = 1; k < 4; k++) begin
            idx = aw'($urandom());
            send_req(SW, make_addr(idx, k[1:0]), $urandom(), $urandom());
            send_req(SH, make_addr(idx, k[1:0]), $urandom(), $urandom());
            send_req(LW, make_addr(idx, k[1:0]), $urandom(), $urandom());
            send_req(LH, make_addr(idx, k[1:0]), $urandom(), $urandom());
            send_req(LHU, make_addr(idx, k[1:0]), $urandom(), $urandom());
            send_req(LW, make_addr(idx, 2'b00), $urandom(), $urandom());
        end

        // Long random mix with few idle cycles.
        for (int i = 0; i < 2000; i++) begin
            r = $urandom();
            if (r[2:0] == 3'd0) begin
                send_idle();
            end else begin
                pick = 4'(r[31:8] % 24'd13);
                idx  = r[7] ? {4'b0, r[6:3]} : r[15:8];    // Small window for more hits.
                send_req(decoded_op_t'(pick), make_addr(idx, r[17:16]), $urandom(), $urandom());
            end
        end
        send_idle();
        send_idle();

        wait_cycles = 0;
        while (rsp_seen != req_sent && wait_cycles < 50) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rsp_seen != req_sent) begin
            timeouts++;
            $display("Timeout: only %0d of %0d responses arrived", rsp_seen, req_sent);
        end

        $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/mips_pkg.sv
src/align_check.sv
src/store_format.sv
src/dmem_access.sv
src/readdata_format.sv
src/mem_stage.sv
verification/mem_stage_tb.sv

// File: Makefile
TOOL       := verilator
TOP        := mem_stage_tb
FILELIST   := verilog.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
